// File: Bender.yml
package:
  name: bch_outer_dec

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bch_pkg.sv
      - hdl/bch_syndrome_count.sv
      - hdl/bch_frame_buffer.sv
      - hdl/bch_locator.sv
      - hdl/bch_chien_search.sv
      - hdl/bch_decision.sv
      - hdl/bch_outer_dec.sv
  - target: test
    include_dirs:
      - hdl
      - tests
    files:
      - tests/tb_bch_outer_dec.sv

// File: all.f
+incdir+hdl
+incdir+tests
hdl/bch_pkg.sv
hdl/bch_syndrome_count.sv
hdl/bch_frame_buffer.sv
hdl/bch_locator.sv
hdl/bch_chien_search.sv
hdl/bch_decision.sv
hdl/bch_outer_dec.sv
tests/tb_bch_outer_dec.sv

// File: hdl/bch_chien_search.sv
/* Chien search over all lanes
   flags error bits, writes fixed and raw data, decides decoder failure */

`default_nettype none

`include "bch_macros.svh"

module bch_chien_search
  import bch_pkg::*;
(
  input  logic                     iclk,
  input  logic                     rst_n,
  input  logic                     iclkena,
  input  logic                     loc_val,
  input  loc_poly_t                loc [`BCH_LANES],
  input  logic                     loc_bank,
  input  lane_t                    rd_dat,
  output logic                     rd_bank,
  output addr_t                    rd_addr,
  output logic                     wr_en,
  output addr_t                    wr_addr,
  output logic [2*`BCH_LANES-1:0]  wr_dat,
  output logic                     done,
  output logic                     done_bank,
  output lane_t                    decfail,
  output err_cnt_t                 err_cnt
);

  chien_state_t state;
  addr_t        cnt;
  logic         bank;
  logic         start;
  logic         last_wr;
  // sig1*a^-i and sig2*a^-2i, stepped every beat
  gf_t          term1     [`BCH_LANES];
  gf_t          term2     [`BCH_LANES];
  gf_t          cur1      [`BCH_LANES];
  gf_t          cur2      [`BCH_LANES];
  logic [1:0]   deg       [`BCH_LANES];
  logic [1:0]   cur_deg   [`BCH_LANES];
  logic [1:0]   roots     [`BCH_LANES];
  logic [1:0]   roots_nxt [`BCH_LANES];
  lane_t        hit;
  lane_t        hit_r;
  lane_t        fail;
  err_cnt_t     cnt_sum;

  // ------------------------------------------------------------------------
  // read stage, address 0 goes out in the loc_val cycle
  // ------------------------------------------------------------------------

  assign start   = (state == CHIEN_IDLE) && loc_val;
  assign rd_addr = (state == CHIEN_SEARCH) ? cnt  : '0;
  assign rd_bank = (state == CHIEN_SEARCH) ? bank : loc_bank;

  // beat j is position 14-j, evaluated at alpha^-(14-j)
  // alpha^-14 = alpha, alpha^-28 = alpha^2
  always_comb begin
    for (int l = 0; l < `BCH_LANES; l++) begin
      if (state == CHIEN_SEARCH) begin
        cur1[l]    = term1[l];
        cur2[l]    = term2[l];
        cur_deg[l] = deg[l];
      end else begin
        cur1[l]    = gf_mul(loc[l].sig1, gf_t'(2));
        cur2[l]    = gf_mul(loc[l].sig2, gf_t'(4));
        cur_deg[l] = loc[l].deg;
      end
      // sigma = 1 + t1 + t2 is zero
      hit[l] = ((cur1[l] ^ cur2[l]) == gf_t'(1));
    end
  end

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= CHIEN_IDLE;
      cnt   <= '0;
      wr_en <= 1'b0;
    end else if (iclkena) begin
      wr_en <= start || (state == CHIEN_SEARCH);
      case (state)
        CHIEN_IDLE: begin
          if (loc_val) begin
            state <= CHIEN_SEARCH;
            cnt   <= addr_t'(1);
          end
        end
        CHIEN_SEARCH: begin
          cnt <= cnt + 1'b1;
          if (cnt == addr_t'(`BCH_N - 1)) begin
            state <= CHIEN_IDLE;
          end
        end
        default: state <= CHIEN_IDLE;
      endcase
    end
  end

  // deg stays valid through the write of the last beat
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      bank    <= rd_bank;
      wr_addr <= rd_addr;
      hit_r   <= hit;
      for (int l = 0; l < `BCH_LANES; l++) begin
        term1[l] <= gf_mul(cur1[l], gf_t'(2));
        term2[l] <= gf_mul(cur2[l], gf_t'(4));
        deg[l]   <= cur_deg[l];
      end
    end
  end

  // ------------------------------------------------------------------------
  // write stage, read data is back
  // ------------------------------------------------------------------------

  // corrected bits high, received bits low
  assign wr_dat  = {rd_dat ^ hit_r, rd_dat};
  assign last_wr = wr_en && (wr_addr == addr_t'(`BCH_N - 1));

  // roots never reach 3, so an unsolvable locator always fails here
  always_comb begin
    cnt_sum = '0;
    for (int l = 0; l < `BCH_LANES; l++) begin
      roots_nxt[l] = ((wr_addr == '0) ? 2'd0 : roots[l]) + 2'(hit_r[l]);
      fail[l]      = (roots_nxt[l] != deg[l]);
      if (!fail[l]) begin
        cnt_sum = cnt_sum + err_cnt_t'(roots_nxt[l]);
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && wr_en) begin
      roots <= roots_nxt;
      if (last_wr) begin
        decfail <= fail;
        err_cnt <= cnt_sum;
      end
    end
  end

  // decision buffer ping-pong, written bank is always ~done_bank
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      done      <= 1'b0;
      done_bank <= 1'b0;
    end else if (iclkena) begin
      done <= last_wr;
      if (last_wr) begin
        done_bank <= ~done_bank;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/bch_decision.sv
/* output decision and framer
   fixed bits for decoded lanes, raw bits for failed ones */

`default_nettype none

`include "bch_macros.svh"

module bch_decision
  import bch_pkg::*;
(
  input  logic                    iclk,
  input  logic                    rst_n,
  input  logic                    iclkena,
  input  logic                    done,
  input  logic                    done_bank,
  input  lane_t                   decfail,
  input  err_cnt_t                err_cnt,
  input  logic [2*`BCH_LANES-1:0] rd_dat,
  output logic                    rd_bank,
  output addr_t                   rd_addr,
  output out_beat_t               out,
  output err_cnt_t                odecerr,
  output lane_t                   odecfail
);

  decision_state_t state;
  addr_t           cnt;
  logic            bank;
  logic            start;
  lane_t           fail_r;
  err_cnt_t        err_r;
  logic            oval;
  logic            osop;
  logic            oeop;
  lane_t           fixed;
  lane_t           raw;

  // ------------------------------------------------------------------------
  // read side, beat 0 address goes out in the done cycle
  // ------------------------------------------------------------------------

  assign start   = (state == DEC_IDLE) && done;
  assign rd_addr = (state == DEC_STREAM) ? cnt  : '0;
  assign rd_bank = (state == DEC_STREAM) ? bank : done_bank;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DEC_IDLE;
      cnt   <= '0;
      oval  <= 1'b0;
      osop  <= 1'b0;
      oeop  <= 1'b0;
    end else if (iclkena) begin
      // flags line up with the registered read data
      oval <= start || (state == DEC_STREAM);
      osop <= start;
      oeop <= (state == DEC_STREAM) && (cnt == addr_t'(`BCH_N - 1));
      case (state)
        DEC_IDLE: begin
          if (done) begin
            state <= DEC_STREAM;
            cnt   <= addr_t'(1);
          end
        end
        DEC_STREAM: begin
          cnt <= cnt + 1'b1;
          if (cnt == addr_t'(`BCH_N - 1)) begin
            state <= DEC_IDLE;
          end
        end
        default: state <= DEC_IDLE;
      endcase
    end
  end

  // frame verdict, held until the eop beat leaves
  always_ff @(posedge iclk) begin
    if (iclkena && start) begin
      bank   <= done_bank;
      fail_r <= decfail;
      err_r  <= err_cnt;
    end
  end

  // ------------------------------------------------------------------------
  // output beat
  // ------------------------------------------------------------------------

  assign fixed = rd_dat[2*`BCH_LANES-1:`BCH_LANES];
  assign raw   = rd_dat[`BCH_LANES-1:0];

  always_comb begin
    out.val = oval;
    out.sop = osop;
    out.eop = oeop;
    out.dat = (fixed & ~fail_r) | (raw & fail_r);
  end

  // frame statistics only on the last beat
  assign odecerr  = oeop ? err_r  : '0;
  assign odecfail = oeop ? fail_r : '0;

endmodule

`default_nettype wire

// File: hdl/bch_frame_buffer.sv
/* two-bank frame memory, one frame per bank, registered read */

`default_nettype none

`include "bch_macros.svh"

module bch_frame_buffer
  import bch_pkg::*;
#(
  parameter int DATA_W = 4
)
(
  input  logic              iclk,
  input  logic              iclkena,
  input  logic              wr_en,
  input  logic              wr_bank,
  input  addr_t             wr_addr,
  input  logic [DATA_W-1:0] wr_dat,
  input  logic              rd_bank,
  input  addr_t             rd_addr,
  output logic [DATA_W-1:0] rd_dat
);

  // bank x beat
  logic [DATA_W-1:0] mem [2][`BCH_N];

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (wr_en) begin
        mem[wr_bank][wr_addr] <= wr_dat;
      end
      // data one enabled cycle after the address
      rd_dat <= mem[rd_bank][rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/bch_locator.sv
/* t=2 error locator for one lane
   direct Peterson solution from S1 and S3, one cycle */

`default_nettype none

module bch_locator
  import bch_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      iclkena,
  input  logic      syn_val,
  input  syndrome_t syn,
  output logic      loc_val,
  output loc_poly_t loc
);

  gf_t       s1_cube;
  gf_t       delta;
  loc_poly_t loc_nxt;

  assign s1_cube = gf_mul(gf_mul(syn.s1, syn.s1), syn.s1);
  // S3 + S1^3 = S1 * X1 * X2
  assign delta   = syn.s3 ^ s1_cube;

  always_comb begin
    loc_nxt = '0;
    if (syn.s1 == '0) begin
      // clean word, or S3 alone which no pair of errors gives
      loc_nxt.deg = (syn.s3 == '0) ? 2'd0 : 2'd3;
    end else if (delta == '0) begin
      // single error at X1 = S1
      loc_nxt.sig1 = syn.s1;
      loc_nxt.deg  = 2'd1;
    end else begin
      loc_nxt.sig1 = syn.s1;
      loc_nxt.sig2 = gf_mul(delta, gf_inv(syn.s1));
      loc_nxt.deg  = 2'd2;
    end
  end

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      loc_val <= 1'b0;
    end else if (iclkena) begin
      loc_val <= syn_val;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && syn_val) begin
      loc <= loc_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/bch_macros.svh
/* BCH(15,7) decoder array sizing
   field degree, code length, lane count and counter widths */

`ifndef BCH_MACROS_SVH
`define BCH_MACROS_SVH

// GF(2^4) symbol width
`define BCH_M       4

// code length, one bit per beat
`define BCH_N       15

// decoders side by side, one bit each per beat
`define BCH_LANES   4

// primitive polynomial x^4 + x + 1
`define BCH_IRRPOL  5'b10011

// beat index inside a frame
`define BCH_ADDR_W  4

// corrected bit counter
`define BCH_ERR_W   8

`endif

// File: hdl/bch_outer_dec.sv
/* BCH(15,7) outer decoder array, 4 lanes
   syndromes, per-lane locators, Chien search and output decision */

`default_nettype none

`include "bch_macros.svh"

module bch_outer_dec
  import bch_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      iclkena,
  input  in_beat_t  in,
  output out_beat_t out,
  output err_cnt_t  odecerr,
  output lane_t     odecfail
);

  // syndrome count and input buffer write
  logic                    in_wr_en;
  logic                    in_wr_bank;
  addr_t                   in_wr_addr;
  lane_t                   in_wr_dat;
  logic                    syn_val;
  logic                    syn_bank;
  syndrome_t               syn [`BCH_LANES];

  // locators
  lane_t                   loc_val;
  loc_poly_t               loc [`BCH_LANES];

  // chien search
  logic                    in_rd_bank;
  addr_t                   in_rd_addr;
  lane_t                   in_rd_dat;
  logic                    dec_wr_en;
  addr_t                   dec_wr_addr;
  logic [2*`BCH_LANES-1:0] dec_wr_dat;
  logic                    done;
  logic                    done_bank;
  lane_t                   decfail;
  err_cnt_t                err_cnt;

  // decision
  logic                    dec_rd_bank;
  addr_t                   dec_rd_addr;
  logic [2*`BCH_LANES-1:0] dec_rd_dat;

  // ------------------------------------------------------------------------
  // syndromes and input frame store
  // ------------------------------------------------------------------------

  bch_syndrome_count syndrome_count (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .iclkena  (iclkena),
    .in       (in),
    .wr_en    (in_wr_en),
    .wr_bank  (in_wr_bank),
    .wr_addr  (in_wr_addr),
    .wr_dat   (in_wr_dat),
    .syn_val  (syn_val),
    .syn_bank (syn_bank),
    .syn      (syn)
  );

  bch_frame_buffer #(
    .DATA_W (`BCH_LANES)
  ) in_buffer (
    .iclk    (iclk),
    .iclkena (iclkena),
    .wr_en   (in_wr_en),
    .wr_bank (in_wr_bank),
    .wr_addr (in_wr_addr),
    .wr_dat  (in_wr_dat),
    .rd_bank (in_rd_bank),
    .rd_addr (in_rd_addr),
    .rd_dat  (in_rd_dat)
  );

  // ------------------------------------------------------------------------
  // one locator per lane
  // ------------------------------------------------------------------------

  for (genvar g = 0; g < `BCH_LANES; g++) begin : loc_gen
    bch_locator locator (
      .iclk    (iclk),
      .rst_n   (rst_n),
      .iclkena (iclkena),
      .syn_val (syn_val),
      .syn     (syn[g]),
      .loc_val (loc_val[g]),
      .loc     (loc[g])
    );
  end

  // ------------------------------------------------------------------------
  // chien search and decision store
  // ------------------------------------------------------------------------

  // all lanes pulse together
  // syn_bank holds until the next frame closes, well past loc_val
  bch_chien_search chien_search (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .iclkena   (iclkena),
    .loc_val   (&loc_val),
    .loc       (loc),
    .loc_bank  (syn_bank),
    .rd_dat    (in_rd_dat),
    .rd_bank   (in_rd_bank),
    .rd_addr   (in_rd_addr),
    .wr_en     (dec_wr_en),
    .wr_addr   (dec_wr_addr),
    .wr_dat    (dec_wr_dat),
    .done      (done),
    .done_bank (done_bank),
    .decfail   (decfail),
    .err_cnt   (err_cnt)
  );

  // fixed and raw bits side by side, writes go opposite the last done bank
  bch_frame_buffer #(
    .DATA_W (2*`BCH_LANES)
  ) dec_buffer (
    .iclk    (iclk),
    .iclkena (iclkena),
    .wr_en   (dec_wr_en),
    .wr_bank (~done_bank),
    .wr_addr (dec_wr_addr),
    .wr_dat  (dec_wr_dat),
    .rd_bank (dec_rd_bank),
    .rd_addr (dec_rd_addr),
    .rd_dat  (dec_rd_dat)
  );

  // ------------------------------------------------------------------------
  // output stream
  // ------------------------------------------------------------------------

  bch_decision decision (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .iclkena   (iclkena),
    .done      (done),
    .done_bank (done_bank),
    .decfail   (decfail),
    .err_cnt   (err_cnt),
    .rd_dat    (dec_rd_dat),
    .rd_bank   (dec_rd_bank),
    .rd_addr   (dec_rd_addr),
    .out       (out),
    .odecerr   (odecerr),
    .odecfail  (odecfail)
  );

endmodule

`default_nettype wire

// File: hdl/bch_pkg.sv
/* BCH decoder array types and GF(16) arithmetic */

`default_nettype none

`include "bch_macros.svh"

package bch_pkg;

  // ------------------------------------------------------------------------
  // vectors
  // ------------------------------------------------------------------------

  typedef logic [`BCH_M-1:0]      gf_t;
  typedef logic [`BCH_LANES-1:0]  lane_t;
  typedef logic [`BCH_ADDR_W-1:0] addr_t;
  typedef logic [`BCH_ERR_W-1:0]  err_cnt_t;

  // ------------------------------------------------------------------------
  // streams and decoder state
  // ------------------------------------------------------------------------

  typedef struct packed {
    logic  val;
    logic  sop;
    lane_t dat;
  } in_beat_t;

  typedef struct packed {
    logic  val;
    logic  sop;
    logic  eop;
    lane_t dat;
  } out_beat_t;

  typedef struct packed {
    gf_t s1;
    gf_t s3;
  } syndrome_t;

  // sigma(x) = 1 + sig1*x + sig2*x^2
  // deg 3 flags a syndrome pair with no t=2 solution
  typedef struct packed {
    gf_t        sig1;
    gf_t        sig2;
    logic [1:0] deg;
  } loc_poly_t;

  typedef enum logic {CHIEN_IDLE, CHIEN_SEARCH} chien_state_t;
  typedef enum logic {DEC_IDLE, DEC_STREAM} decision_state_t;

  // ------------------------------------------------------------------------
  // field arithmetic
  // ------------------------------------------------------------------------

  // shift and add, reduce on every carry out
  function automatic gf_t gf_mul(gf_t a, gf_t b);
    logic [`BCH_M:0] poly;
    gf_t             acc;
    gf_t             sh;
    poly = `BCH_IRRPOL;
    acc  = '0;
    sh   = a;
    for (int i = 0; i < `BCH_M; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[`BCH_M-2:0], 1'b0} ^ (sh[`BCH_M-1] ? poly[`BCH_M-1:0] : '0);
    end
    return acc;
  endfunction

  // a^-1 = a^14 = a^2 * a^4 * a^8, zero stays zero
  function automatic gf_t gf_inv(gf_t a);
    gf_t a2;
    gf_t a4;
    gf_t a8;
    a2 = gf_mul(a, a);
    a4 = gf_mul(a2, a2);
    a8 = gf_mul(a4, a4);
    return gf_mul(gf_mul(a2, a4), a8);
  endfunction

endpackage

`default_nettype wire

// File: hdl/bch_syndrome_count.sv
/* BCH syndrome counter
   serial S1/S3 per lane while the frame is written into the input buffer */

`default_nettype none

`include "bch_macros.svh"

module bch_syndrome_count
  import bch_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      iclkena,
  input  in_beat_t  in,
  output logic      wr_en,
  output logic      wr_bank,
  output addr_t     wr_addr,
  output lane_t     wr_dat,
  output logic      syn_val,
  output logic      syn_bank,
  output syndrome_t syn [`BCH_LANES]
);

  addr_t cnt;
  addr_t pos;
  logic  last;

  // sop always means beat 0
  assign pos  = in.sop ? '0 : cnt;
  assign last = in.val && (pos == addr_t'(`BCH_N - 1));

  // buffer write side, beat k to address k
  assign wr_en   = in.val;
  assign wr_addr = pos;
  assign wr_dat  = in.dat;

  // ------------------------------------------------------------------------
  // beat counter and bank ping-pong
  // ------------------------------------------------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      wr_bank  <= 1'b0;
      syn_val  <= 1'b0;
      syn_bank <= 1'b0;
    end else if (iclkena) begin
      syn_val <= last;
      if (in.val) begin
        // wrap after beat 14, so a missing sop still frames
        cnt <= last ? '0 : pos + 1'b1;
      end
      if (last) begin
        syn_bank <= wr_bank;
        wr_bank  <= ~wr_bank;
      end
    end
  end

  // ------------------------------------------------------------------------
  // horner accumulation, first beat is x^14
  // ------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && in.val) begin
      for (int l = 0; l < `BCH_LANES; l++) begin
        if (pos == '0) begin
          syn[l].s1 <= gf_t'(in.dat[l]);
          syn[l].s3 <= gf_t'(in.dat[l]);
        end else begin
          // r(alpha) and r(alpha^3)
          syn[l].s1 <= gf_mul(syn[l].s1, gf_t'(2)) ^ gf_t'(in.dat[l]);
          syn[l].s3 <= gf_mul(syn[l].s3, gf_t'(8)) ^ gf_t'(in.dat[l]);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_bch_model.svh
/* BCH(15,7) reference model for the decoder testbench
   LCG, systematic encoder and brute-force nearest codeword search */

`ifndef TB_BCH_MODEL_SVH
`define TB_BCH_MODEL_SVH

// one lane's frame, bit i is the x^i coefficient
typedef logic [`BCH_N-1:0] word_t;

// g(x) = x^8 + x^7 + x^6 + x^4 + 1
localparam logic [8:0] GEN_POLY = 9'h1d1;
localparam int         MSG_W    = 7;

logic [31:0] lcg_state = 32'hf592f918;

// numerical recipes constants
function logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// upper bits only, low bits of an LCG cycle fast
function int rand_below(int n);
  return int'(lcg_next() >> 8) % n;
endfunction

function automatic int weight(word_t w);
  int c;
  c = 0;
  for (int i = 0; i < `BCH_N; i++) begin
    c += w[i];
  end
  return c;
endfunction

// systematic, message in x^14..x^8, remainder of m(x)x^8 / g(x) below
function automatic word_t encode_msg(logic [MSG_W-1:0] msg);
  word_t r;
  r = {msg, 8'h00};
  for (int i = `BCH_N - 1; i >= 8; i--) begin
    if (r[i]) begin
      r = r ^ (word_t'(GEN_POLY) << (i - 8));
    end
  end
  return {msg, r[7:0]};
endfunction

// n distinct flipped positions
function automatic word_t error_mask(int n);
  word_t m;
  m = '0;
  while (weight(m) < n) begin
    m[rand_below(`BCH_N)] = 1'b1;
  end
  return m;
endfunction

// dmin is 5, so at most one codeword lies within distance 2
task automatic nearest_codeword(input word_t rx, output logic found, output word_t cw);
  word_t cand;
  found = 1'b0;
  cw    = rx;
  for (int m = 0; m < (1 << MSG_W); m++) begin
    cand = encode_msg(MSG_W'(m));
    if (!found && weight(rx ^ cand) <= 2) begin
      found = 1'b1;
      cw    = cand;
    end
  end
endtask

`endif

// File: tests/tb_bch_outer_dec.sv
/* testbench for the BCH(15,7) outer decoder array
   directed frames against a brute-force reference decoder */

`default_nettype none

`include "bch_macros.svh"

module tb_bch_outer_dec
  import bch_pkg::*;
;

  `include "tb_bch_model.svh"

  // frames per test
  localparam int N_CLEAN  = 4;
  localparam int N_SINGLE = 6;
  localparam int N_DOUBLE = 6;
  localparam int N_HEAVY  = 8;
  localparam int N_STREAM = 12;
  localparam int N_FRAMES = N_CLEAN + N_SINGLE + N_DOUBLE + N_HEAVY + N_STREAM;
  localparam int LIMIT    = 40 * N_FRAMES + 100;

  typedef logic [`BCH_LANES-1:0][2:0] nerr_t;

  logic      iclk = 1'b0;
  logic      rst_n;
  logic      iclkena;
  in_beat_t  in;
  out_beat_t out;
  err_cnt_t  odecerr;
  lane_t     odecfail;

  // expected output queues with 15 exp_dat beats per frame
  lane_t     exp_dat  [$];
  err_cnt_t  exp_cnt  [$];
  lane_t     exp_fail [$];
  int        frames_sent = 0;
  int        frames_out  = 0;
  int        beat_idx    = 0;
  int        cycles      = 0;

  bch_outer_dec dut (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .iclkena  (iclkena),
    .in       (in),
    .out      (out),
    .odecerr  (odecerr),
    .odecfail (odecfail)
  );

  always #2 iclk = ~iclk;

  // --------------------------------------------------------------------------
  // error reporting and compares
  // --------------------------------------------------------------------------

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_lane(input string name, input lane_t got, input lane_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_cnt(input string name, input err_cnt_t got, input err_cnt_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED time %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED time %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // output monitor counting beats on enabled rising edges
  // --------------------------------------------------------------------------

  always @(posedge iclk) begin
    if (rst_n && iclkena && out.val) begin
      if (exp_dat.size() == 0) begin
        fail_run("output beat arrived with no frame left to expect");
      end
      if (beat_idx == 0 && !out.sop) begin
        fail_run("output frame started without osop");
      end
      if (beat_idx == `BCH_N - 1 && !out.eop) begin
        fail_run("output frame reached 15 beats without oeop");
      end
      check_flag("out.sop", out.sop, beat_idx == 0);
      check_flag("out.eop", out.eop, beat_idx == `BCH_N - 1);
      check_lane("out.dat", out.dat, exp_dat.pop_front());
      if (beat_idx == `BCH_N - 1) begin
        // frame verdict sits on the eop beat
        check_cnt("odecerr", odecerr, exp_cnt.pop_front());
        check_lane("odecfail", odecfail, exp_fail.pop_front());
        beat_idx = 0;
        frames_out++;
      end else begin
        check_cnt("odecerr", odecerr, '0);
        check_lane("odecfail", odecfail, '0);
        beat_idx++;
      end
    end
  end

  // run length guard
  always @(posedge iclk) begin
    cycles++;
    if (cycles > LIMIT) begin
      fail_run($sformatf("timeout after %0d cycles, %0d of %0d frames came out",
                         cycles, frames_out, frames_sent));
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  // held until an enabled edge takes it
  task automatic send_beat(input lane_t dat, input logic sop, input bit jitter);
    if (jitter) begin
      while (rand_below(4) == 0) begin
        @(negedge iclk);
        in      = '0;
        iclkena = rand_below(2) != 0;
      end
    end
    do begin
      @(negedge iclk);
      in      = {1'b1, sop, dat};
      iclkena = jitter ? (rand_below(4) != 0) : 1'b1;
    end while (!iclkena);
  endtask

  // random message per lane with nerr flips and the model's verdict
  task automatic send_frame(input nerr_t nerr, input bit jitter);
    word_t    rx   [`BCH_LANES];
    word_t    want [`BCH_LANES];
    word_t    cw;
    logic     found;
    err_cnt_t cnt;
    lane_t    fail;
    lane_t    beat;
    cnt  = '0;
    fail = '0;
    for (int l = 0; l < `BCH_LANES; l++) begin
      cw    = encode_msg(MSG_W'(rand_below(1 << MSG_W)));
      rx[l] = cw ^ error_mask(nerr[l]);
      nearest_codeword(rx[l], found, cw);
      if (found) begin
        want[l] = cw;
        cnt     = cnt + err_cnt_t'(weight(rx[l] ^ cw));
      end else begin
        // undecodable lane leaves raw
        want[l] = rx[l];
        fail[l] = 1'b1;
      end
    end
    for (int j = 0; j < `BCH_N; j++) begin
      for (int l = 0; l < `BCH_LANES; l++) begin
        beat[l] = want[l][`BCH_N-1-j];
      end
      exp_dat.push_back(beat);
    end
    exp_cnt.push_back(cnt);
    exp_fail.push_back(fail);
    frames_sent++;
    // first beat is x^14
    for (int j = 0; j < `BCH_N; j++) begin
      for (int l = 0; l < `BCH_LANES; l++) begin
        beat[l] = rx[l][`BCH_N-1-j];
      end
      send_beat(beat, j == 0, jitter);
    end
  endtask

  task automatic drain();
    @(negedge iclk);
    in      = '0;
    iclkena = 1'b1;
    while (frames_out < frames_sent) begin
      @(negedge iclk);
    end
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic clean_frames();
    for (int f = 0; f < N_CLEAN; f++) begin
      send_frame('0, 1'b0);
    end
    drain();
  endtask

  task automatic single_errors();
    nerr_t nerr;
    for (int l = 0; l < `BCH_LANES; l++) begin
      nerr[l] = 3'd1;
    end
    for (int f = 0; f < N_SINGLE; f++) begin
      send_frame(nerr, 1'b0);
    end
    drain();
  endtask

  // at least one lane with two errors and one clean lane per frame
  task automatic double_errors();
    nerr_t nerr;
    for (int f = 0; f < N_DOUBLE; f++) begin
      for (int l = 0; l < `BCH_LANES; l++) begin
        nerr[l] = (rand_below(2) != 0) ? 3'd2 : 3'd0;
      end
      nerr[f % `BCH_LANES]       = 3'd2;
      nerr[(f + 1) % `BCH_LANES] = 3'd0;
      send_frame(nerr, 1'b0);
    end
    drain();
  endtask

  // one lane beyond t with the rest anywhere from 0 to 5
  task automatic heavy_errors();
    nerr_t nerr;
    for (int f = 0; f < N_HEAVY; f++) begin
      for (int l = 0; l < `BCH_LANES; l++) begin
        nerr[l] = 3'(rand_below(6));
      end
      nerr[f % `BCH_LANES] = 3'(3 + rand_below(3));
      send_frame(nerr, 1'b0);
    end
    drain();
  endtask

  // gaps and iclkena stalls on the way in
  task automatic stalled_stream();
    nerr_t nerr;
    for (int f = 0; f < N_STREAM; f++) begin
      for (int l = 0; l < `BCH_LANES; l++) begin
        nerr[l] = 3'(rand_below(5));
      end
      send_frame(nerr, 1'b1);
    end
    drain();
  endtask

  initial begin
    rst_n   = 1'b0;
    iclkena = 1'b0;
    in      = '0;
    repeat (2) @(negedge iclk);
    rst_n   = 1'b1;
    iclkena = 1'b1;
    check_flag("out.val after reset", out.val, 1'b0);
    clean_frames();
    single_errors();
    double_errors();
    heavy_errors();
    stalled_stream();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
